/* src.f */
hw/corr_pkg.sv
hw/pulse_frontend.sv
hw/correlator.sv
hw/cmd_parser.sv
hw/packet_tx.sv
hw/corr_main.sv
tests/corr_assert.sv
tests/tb_corr.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_corr -f src.f -o sim_corr

./obj_dir/sim_corr | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

/* tests/tb_corr.sv */
// Testbench for the coincidence correlator top level.
// Drives LFSR line activity and command bytes, mirrors the counters in a
// cycle-by-cycle model and checks every ASCII hex packet the DUT sends.

`timescale 1ns/1ps

module tb_corr;

	localparam int N = corr_pkg::num_inputs_def;
	localparam int LA = corr_pkg::lag_auto_def;
	localparam int LC = corr_pkg::lag_cross_def;
	localparam int RES = corr_pkg::resolution_def;
	localparam int GAP = corr_pkg::tx_gap_def;
	localparam int MAXL = (LA > LC - 1) ? LA : LC - 1;
	localparam int NC = N + N * LA + (N * (N - 1) / 2) * (2 * LC - 1);
	localparam int PKT_LEN = 8 + NC * RES / 4 + 8 + 1;	// header, counts, footer, cr.
	localparam int TIMEOUT = 30000;
	localparam int PEND_NONE = 0;
	localparam int PEND_START = 1;
	localparam int PEND_INV = 2;
	localparam int PEND_EDGE = 3;

	logic intclk;
	logic rst_n;
	logic [N-1:0] line_in;
	logic [7:0] rx_data;
	logic rx_valid;
	logic [7:0] tx_data;
	logic tx_valid;
	logic integrating;
	logic tx_busy;

	logic [15:0] lfsr;
	int cyc;
	int line_mode;	// 0 random, 1 all high, 2 all low.
	logic int_before;
	logic busy_before;
	int pend_kind;
	int pend_line;
	logic pend_val;
	logic [N-1:0] m_inv;
	logic [N-1:0] m_edge;
	logic [N-1:0] m_prev;
	logic [MAXL:0] m_hist [N];
	int m_cnt [NC];
	logic [31:0] m_win;
	logic [7:0] pkt_bytes [$];
	int pkt_cycs [$];
	logic [3:0] pkt_nibs [$];
	int int_fall_cyc;
	int busy_rise_cyc;
	logic int_seen;
	logic busy_seen;

	corr_main #(
		.NUM_INPUTS(N), .LAG_AUTO(LA), .LAG_CROSS(LC), .RESOLUTION(RES), .TX_GAP(GAP)
	) u_dut (
		.intclk(intclk), .rst_n(rst_n), .line_in(line_in), .rx_data(rx_data),
		.rx_valid(rx_valid), .tx_data(tx_data), .tx_valid(tx_valid),
		.integrating(integrating), .tx_busy(tx_busy)
	);

	initial begin
		intclk = 1'b0;
		forever #4 intclk = ~intclk;
	end

	always @(posedge intclk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT)
			fail_now($sformatf("run did not finish within %0d cycles", TIMEOUT));
	end

	// packet capture, sampled mid cycle.
	always @(negedge intclk) begin
		if (rst_n) begin
			if (tx_valid) begin
				pkt_bytes.push_back(tx_data);
				pkt_cycs.push_back(cyc);
			end
			if (int_seen && !integrating)
				int_fall_cyc = cyc;
			if (!busy_seen && tx_busy)
				busy_rise_cyc = cyc;
			int_seen = integrating;
			busy_seen = tx_busy;
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_now($sformatf("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	// galois lfsr, one step per bit.
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	function automatic int sat_add(input int v, input logic hit);
		if (hit && v < (1 << RES) - 1)
			return v + 1;
		return v;
	endfunction

	function automatic logic [7:0] head_byte(input logic [3:0] op, input logic [3:0] chan);
		corr_pkg::cmd_byte_u cb;
		cb.head.op = op;
		cb.head.chan = chan;
		return cb.data.val;
	endfunction

	function automatic logic is_hex(input logic [7:0] c);
		return (c >= "0" && c <= "9") || (c >= "A" && c <= "F");
	endfunction

	function automatic logic [3:0] hex_value(input logic [7:0] c);
		if (c <= "9")
			return 4'(c - "0");
		return 4'(c - "A" + 8'd10);
	endfunction

	function automatic logic [31:0] field(input int pos, input int len);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < len; i++)
			v = (v << 4) | 32'(pkt_nibs[pos+i]);
		return v;
	endfunction

	// ****************************************
	// reference model, one call per edge
	// ****************************************
	task automatic model_edge();
		logic [N-1:0] samp;
		logic [N-1:0] pulse;
		int n;
		if (pend_kind == PEND_START && !busy_before) begin
			for (int c = 0; c < NC; c++)
				m_cnt[c] = 0;
			m_win = '0;
		end else if (int_before) begin
			n = 0;
			for (int i = 0; i < N; i++) begin
				m_cnt[n] = sat_add(m_cnt[n], m_hist[i][0]);
				n++;
			end
			for (int i = 0; i < N; i++) begin
				for (int l = 1; l <= LA; l++) begin
					m_cnt[n] = sat_add(m_cnt[n], m_hist[i][0] & m_hist[i][l]);
					n++;
				end
			end
			for (int i = 0; i < N; i++) begin
				for (int j = i + 1; j < N; j++) begin
					for (int k = -(LC - 1); k <= LC - 1; k++) begin
						if (k >= 0)
							m_cnt[n] = sat_add(m_cnt[n], m_hist[i][0] & m_hist[j][k]);
						else
							m_cnt[n] = sat_add(m_cnt[n], m_hist[i][-k] & m_hist[j][0]);
						n++;
					end
				end
			end
			if (m_win != 32'hFFFF_FFFF)
				m_win = m_win + 32'd1;
		end
		samp = line_in ^ m_inv;
		for (int i = 0; i < N; i++) begin
			if (m_edge[i])
				pulse[i] = samp[i] & !(m_prev[i] ^ m_inv[i]);	// rising edge only.
			else
				pulse[i] = samp[i];
			m_hist[i] = {m_hist[i][MAXL-1:0], pulse[i]};
		end
		m_prev = line_in;
		if (pend_kind == PEND_INV)
			m_inv[pend_line] = pend_val;
		else if (pend_kind == PEND_EDGE)
			m_edge[pend_line] = pend_val;
	endtask

	task automatic cycle();
		@(posedge intclk);
		model_edge();
		#1;
		int_before = integrating;
		busy_before = tx_busy;
		rx_valid = 1'b0;
		pend_kind = PEND_NONE;
		case (line_mode)
			0: line_in = N'(random_bits(N));
			1: line_in = '1;
			default: line_in = '0;
		endcase
	endtask

	task automatic send_byte(input logic [7:0] b, input int kind, input int line,
		input logic val);
		rx_data = b;
		rx_valid = 1'b1;
		pend_kind = kind;
		pend_line = line;
		pend_val = val;
		cycle();
		cycle();	// keeps bytes two cycles apart.
	endtask

	task automatic set_option(input logic [3:0] op, input int line, input logic val);
		send_byte(head_byte(op, 4'(line)), PEND_NONE, 0, 1'b0);
		send_byte({7'd0, val}, (op == corr_pkg::op_invert) ? PEND_INV : PEND_EDGE, line, val);
	endtask

	task automatic run_window(input int len);
		send_byte(head_byte(corr_pkg::op_start, 4'd0), PEND_START, 0, 1'b0);
		check("integrating", 32'(integrating), 32'd1);
		repeat (len) cycle();
		pkt_bytes.delete();
		pkt_cycs.delete();
		send_byte(head_byte(corr_pkg::op_stop, 4'd0), PEND_NONE, 0, 1'b0);
		check("integrating", 32'(integrating), 32'd0);
	endtask

	task automatic wait_packet();
		while (!tx_busy)
			cycle();
		while (tx_busy)
			cycle();
	endtask

	task automatic check_packet();
		logic [31:0] footer;
		logic [31:0] val;
		check("packet byte count", 32'(pkt_bytes.size()), 32'(PKT_LEN));
		pkt_nibs.delete();
		for (int b = 0; b < PKT_LEN - 1; b++) begin
			if (!is_hex(pkt_bytes[b]))
				fail_now($sformatf("packet byte %0d (%0h) is not an ASCII hex digit",
					b, pkt_bytes[b]));
			pkt_nibs.push_back(hex_value(pkt_bytes[b]));
		end
		check("terminator", 32'(pkt_bytes[PKT_LEN-1]), 32'(corr_pkg::crlf_char));
		check("header lines", field(0, 2), 32'(N - 1));
		check("header lag_auto", field(2, 2), 32'(LA));
		check("header lag_cross", field(4, 2), 32'(LC));
		check("header resolution", field(6, 2), 32'(RES / 4));
		footer = field(8 + NC * RES / 4, 8);
		check("win_cycles", footer, m_win);
		for (int c = 0; c < NC; c++) begin
			val = field(8 + c * RES / 4, RES / 4);
			check($sformatf("count[%0d]", c), val, 32'(m_cnt[c]));
			if (val > footer)
				fail_now($sformatf("count %0d is larger than the window length", c));
		end
		check("snapshot cycle", 32'(busy_rise_cyc), 32'(int_fall_cyc + 1));
		check("first byte cycle", 32'(pkt_cycs[0]), 32'(busy_rise_cyc + GAP));
		for (int b = 1; b < PKT_LEN; b++)
			check($sformatf("byte %0d spacing", b), 32'(pkt_cycs[b] - pkt_cycs[b-1]), 32'(GAP));
	endtask

	initial begin
		rst_n = 1'b0;
		line_in = '0;
		rx_data = '0;
		rx_valid = 1'b0;
		lfsr = 16'd43858;
		cyc = 0;
		line_mode = 2;
		pend_kind = PEND_NONE;
		pend_line = 0;
		pend_val = 1'b0;
		m_inv = '0;
		m_edge = '0;
		m_prev = '0;
		m_win = '0;
		int_seen = 1'b0;
		busy_seen = 1'b0;
		int_fall_cyc = 0;
		busy_rise_cyc = 0;
		for (int i = 0; i < N; i++)
			m_hist[i] = '0;
		for (int c = 0; c < NC; c++)
			m_cnt[c] = 0;
		repeat (2) @(posedge intclk);
		#1;
		rst_n = 1'b1;
		int_before = integrating;
		busy_before = tx_busy;

		// idle state and an empty window.
		repeat (3) cycle();
		check("integrating", 32'(integrating), 32'd0);
		check("tx_valid", 32'(tx_valid), 32'd0);
		check("tx_busy", 32'(tx_busy), 32'd0);
		run_window(5 + random_bits(4));
		wait_packet();
		check_packet();

		// plain mode, random lines.
		line_mode = 0;
		run_window(40 + random_bits(8));
		wait_packet();
		check_packet();

		// random invert and edge options.
		for (int i = 0; i < N; i++) begin
			set_option(corr_pkg::op_invert, i, lfsr_bit());
			set_option(corr_pkg::op_edge, i, lfsr_bit());
		end
		run_window(40 + random_bits(8));
		wait_packet();
		check_packet();

		// START during transmission is dropped.
		run_window(40 + random_bits(8));
		send_byte(head_byte(corr_pkg::op_start, 4'd0), PEND_START, 0, 1'b0);
		check("integrating", 32'(integrating), 32'd0);
		check("tx_busy", 32'(tx_busy), 32'd1);
		wait_packet();
		check_packet();
		run_window(40 + random_bits(8));
		wait_packet();
		check_packet();

		// all lines high, counts bounded by the window.
		for (int i = 0; i < N; i++) begin
			set_option(corr_pkg::op_invert, i, 1'b0);
			set_option(corr_pkg::op_edge, i, 1'b0);
		end
		line_mode = 1;
		run_window(100 + random_bits(7));
		wait_packet();
		check_packet();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* tests/corr_assert.sv */
// Concurrent protocol checks on the correlator top level.
// Bound into corr_main; covers the transmit strobe and the state after reset.

`timescale 1ns/1ps

module corr_assert (
	input logic intclk,
	input logic rst_n,
	input logic tx_valid,
	input logic tx_busy,
	input logic integrating
);

	// one strobe per byte, never back to back.
	strobe_single: assert property (@(posedge intclk) disable iff (!rst_n)
		tx_valid |=> !tx_valid)
		else $error("tx_valid high on two consecutive cycles");

	strobe_in_busy: assert property (@(posedge intclk) disable iff (!rst_n)
		tx_valid |-> tx_busy)
		else $error("tx_valid high while tx_busy is low");

	idle_after_reset: assert property (@(posedge intclk)
		$rose(rst_n) |-> !integrating)
		else $error("integrating set in the first cycle after reset");

endmodule

bind corr_main corr_assert u_assert (
	.intclk(intclk),
	.rst_n(rst_n),
	.tx_valid(tx_valid),
	.tx_busy(tx_busy),
	.integrating(integrating)
);

/* hw/corr_main.sv */
// Top level of the photon-coincidence correlator.
// Byte commands in, ASCII hex result packets out, all on intclk.

`timescale 1ns/1ps

module corr_main #(
	parameter int NUM_INPUTS = corr_pkg::num_inputs_def,
	parameter int LAG_AUTO = corr_pkg::lag_auto_def,
	parameter int LAG_CROSS = corr_pkg::lag_cross_def,
	parameter int RESOLUTION = corr_pkg::resolution_def,
	parameter int TX_GAP = corr_pkg::tx_gap_def
) (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  logic [7:0]            rx_data,
	input  logic                  rx_valid,
	output logic [7:0]            tx_data,
	output logic                  tx_valid,
	output logic                  integrating,
	output logic                  tx_busy
);

	localparam int MAX_LAG = corr_pkg::max_lag(LAG_AUTO, LAG_CROSS);
	localparam int NUM_COUNTS = corr_pkg::count_total(NUM_INPUTS, LAG_AUTO, LAG_CROSS);

	logic [NUM_INPUTS-1:0] invert_mask;
	logic [NUM_INPUTS-1:0] edge_mask;
	logic clear_counts;
	logic [NUM_INPUTS*(MAX_LAG+1)-1:0] pulse_hist;
	logic [NUM_COUNTS*RESOLUTION-1:0] count_bus;	// packet order.
	logic [31:0] win_cycles;

	cmd_parser #(.NUM_INPUTS(NUM_INPUTS)) u_parser (
		.intclk(intclk), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid),
		.tx_busy(tx_busy), .invert_mask(invert_mask), .edge_mask(edge_mask),
		.integrating(integrating), .clear_counts(clear_counts)
	);

	pulse_frontend #(.NUM_INPUTS(NUM_INPUTS), .MAX_LAG(MAX_LAG)) u_frontend (
		.intclk(intclk), .rst_n(rst_n), .line_in(line_in), .invert_mask(invert_mask),
		.edge_mask(edge_mask), .pulse_hist(pulse_hist)
	);

	correlator #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_AUTO(LAG_AUTO), .LAG_CROSS(LAG_CROSS),
		.RESOLUTION(RESOLUTION)
	) u_correlator (
		.intclk(intclk), .rst_n(rst_n), .pulse_hist(pulse_hist), .integrating(integrating),
		.clear_counts(clear_counts), .count_bus(count_bus), .win_cycles(win_cycles)
	);

	packet_tx #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_AUTO(LAG_AUTO), .LAG_CROSS(LAG_CROSS),
		.RESOLUTION(RESOLUTION), .TX_GAP(TX_GAP)
	) u_tx (
		.intclk(intclk), .rst_n(rst_n), .integrating(integrating), .count_bus(count_bus),
		.win_cycles(win_cycles), .tx_data(tx_data), .tx_valid(tx_valid), .tx_busy(tx_busy)
	);

endmodule

/* hw/packet_tx.sv */
// Result packet transmitter.
// Snapshots the counters when the window closes and sends header, payload
// and window length as ASCII hex, MSB nibble first, then a carriage return.
// One byte strobe every TX_GAP cycles.

`timescale 1ns/1ps

module packet_tx #(
	parameter int NUM_INPUTS = corr_pkg::num_inputs_def,
	parameter int LAG_AUTO = corr_pkg::lag_auto_def,
	parameter int LAG_CROSS = corr_pkg::lag_cross_def,
	parameter int RESOLUTION = corr_pkg::resolution_def,
	parameter int TX_GAP = corr_pkg::tx_gap_def,
	localparam int NUM_COUNTS = corr_pkg::count_total(NUM_INPUTS, LAG_AUTO, LAG_CROSS)
) (
	input  logic                             intclk,
	input  logic                             rst_n,
	input  logic                             integrating,
	input  logic [NUM_COUNTS*RESOLUTION-1:0] count_bus,
	input  logic [31:0]                      win_cycles,
	output logic [7:0]                       tx_data,
	output logic                             tx_valid,
	output logic                             tx_busy
);

	localparam int FRAME_BITS = 32 + NUM_COUNTS * RESOLUTION + 32;
	localparam int NIBBLES = FRAME_BITS / 4;
	localparam int IDX_W = $clog2(NIBBLES + 2);
	localparam int GAP_W = $clog2(TX_GAP + 1);
	localparam logic [IDX_W-1:0] DONE = IDX_W'(NIBBLES + 1);	// all bytes out.

	logic [FRAME_BITS-1:0] frame;
	logic [IDX_W-1:0] idx;
	logic [GAP_W-1:0] gap;
	logic int_q;
	logic snap;
	logic emit;

	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		return (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h37 + 8'(nib);
	endfunction

	assign snap = !tx_busy && int_q && !integrating;
	assign emit = tx_busy && (idx != DONE) && (gap == '0);

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			int_q <= 1'b0;
			tx_busy <= 1'b0;
			tx_valid <= 1'b0;
			idx <= '0;
			gap <= '0;
		end else begin
			int_q <= integrating;
			tx_valid <= emit;
			if (snap) begin
				tx_busy <= 1'b1;
				idx <= '0;
				gap <= GAP_W'(TX_GAP - 1);
			end else if (tx_busy && idx == DONE) begin
				tx_busy <= 1'b0;	// drops as the last strobe ends.
			end else if (emit) begin
				idx <= idx + 1'b1;
				gap <= GAP_W'(TX_GAP - 1);
			end else if (tx_busy) begin
				gap <= gap - 1'b1;
			end
		end
	end

	// ****************************************
	// frame shifter
	// ****************************************
	always_ff @(posedge intclk) begin
		if (snap) begin
			frame <= {8'(NUM_INPUTS - 1), 8'(LAG_AUTO), 8'(LAG_CROSS), 8'(RESOLUTION / 4),
				count_bus, win_cycles};
		end else if (emit) begin
			frame <= frame << 4;
			tx_data <= (idx < IDX_W'(NIBBLES)) ? hex_char(frame[FRAME_BITS-1 -: 4]) :
				corr_pkg::crlf_char;
		end
	end

endmodule

/* hw/cmd_parser.sv */
// Command byte decoder.
// Opens and closes the integration window and holds the per-line invert
// and edge options. INVERT and EDGE take one argument byte after the head.

`timescale 1ns/1ps

module cmd_parser #(
	parameter int NUM_INPUTS = corr_pkg::num_inputs_def
) (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [7:0]            rx_data,
	input  logic                  rx_valid,
	input  logic                  tx_busy,
	output logic [NUM_INPUTS-1:0] invert_mask,
	output logic [NUM_INPUTS-1:0] edge_mask,
	output logic                  integrating,
	output logic                  clear_counts
);

	corr_pkg::cmd_byte_u cmd;
	logic arg_wait;	// second state, argument byte expected.
	logic [3:0] arg_op;
	logic [3:0] arg_chan;

	assign cmd.data.val = rx_data;

	// counters clear on the same edge that opens the window.
	assign clear_counts = rx_valid && !arg_wait && !tx_busy &&
		(cmd.head.op == corr_pkg::op_start);

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			arg_wait <= 1'b0;
			integrating <= 1'b0;
			invert_mask <= '0;
			edge_mask <= '0;
		end else if (rx_valid) begin
			if (arg_wait) begin
				arg_wait <= 1'b0;
				for (int i = 0; i < NUM_INPUTS; i++) begin
					if (int'(arg_chan) == i) begin
						if (arg_op == corr_pkg::op_invert)
							invert_mask[i] <= cmd.data.val[0];
						else
							edge_mask[i] <= cmd.data.val[0];
					end
				end
			end else begin
				case (cmd.head.op)
					corr_pkg::op_invert, corr_pkg::op_edge: arg_wait <= 1'b1;
					corr_pkg::op_start: if (!tx_busy) integrating <= 1'b1;
					corr_pkg::op_stop: integrating <= 1'b0;
					default: ;	// unknown opcode.
				endcase
			end
		end
	end

	// head fields kept for the argument byte.
	always_ff @(posedge intclk) begin
		if (rx_valid && !arg_wait) begin
			arg_op <= cmd.head.op;
			arg_chan <= cmd.head.chan;
		end
	end

endmodule

/* hw/correlator.sv */
// Window-gated coincidence counters.
// Holds the per-line pulse counts, the autocorrelation and crosscorrelation
// counts and the window length. All counters saturate and are flattened
// onto count_bus in packet order, first counter in the top bits.

`timescale 1ns/1ps

module correlator #(
	parameter int NUM_INPUTS = corr_pkg::num_inputs_def,
	parameter int LAG_AUTO = corr_pkg::lag_auto_def,
	parameter int LAG_CROSS = corr_pkg::lag_cross_def,
	parameter int RESOLUTION = corr_pkg::resolution_def,
	localparam int MAX_LAG = corr_pkg::max_lag(LAG_AUTO, LAG_CROSS),
	localparam int NUM_COUNTS = corr_pkg::count_total(NUM_INPUTS, LAG_AUTO, LAG_CROSS)
) (
	input  logic                              intclk,
	input  logic                              rst_n,
	input  logic [NUM_INPUTS*(MAX_LAG+1)-1:0] pulse_hist,
	input  logic                              integrating,
	input  logic                              clear_counts,
	output logic [NUM_COUNTS*RESOLUTION-1:0]  count_bus,
	output logic [31:0]                       win_cycles
);

	localparam int W = MAX_LAG + 1;

	logic [RESOLUTION-1:0] cnt [NUM_COUNTS];
	logic [NUM_COUNTS-1:0] hit;

	// ****************************************
	// coincidence terms, in payload order
	// ****************************************
	always_comb begin
		int n;
		n = 0;
		hit = '0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			hit[n] = pulse_hist[i*W];
			n++;
		end
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int l = 1; l <= LAG_AUTO; l++) begin
				hit[n] = pulse_hist[i*W] & pulse_hist[i*W+l];
				n++;
			end
		end
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int j = i + 1; j < NUM_INPUTS; j++) begin
				for (int k = 1 - LAG_CROSS; k < LAG_CROSS; k++) begin
					if (k >= 0)
						hit[n] = pulse_hist[i*W] & pulse_hist[j*W+k];	// line j leads.
					else
						hit[n] = pulse_hist[i*W-k] & pulse_hist[j*W];
					n++;
				end
			end
		end
	end

	// clear wins over counting on the start edge.
	always_ff @(posedge intclk) begin
		if (!rst_n || clear_counts) begin
			for (int c = 0; c < NUM_COUNTS; c++)
				cnt[c] <= '0;
			win_cycles <= '0;
		end else if (integrating) begin
			for (int c = 0; c < NUM_COUNTS; c++) begin
				if (hit[c] && !(&cnt[c]))
					cnt[c] <= cnt[c] + 1'b1;
			end
			if (!(&win_cycles))
				win_cycles <= win_cycles + 32'd1;
		end
	end

	always_comb begin
		for (int c = 0; c < NUM_COUNTS; c++)
			count_bus[(NUM_COUNTS-1-c)*RESOLUTION +: RESOLUTION] = cnt[c];
	end

endmodule

/* hw/pulse_frontend.sv */
// Detector line front end.
// Samples the lines, applies per-line invert and rising edge modes and
// keeps the pulse history that the correlator taps for its lags.

`timescale 1ns/1ps

module pulse_frontend #(
	parameter int NUM_INPUTS = corr_pkg::num_inputs_def,
	parameter int MAX_LAG = 2
) (
	input  logic                              intclk,
	input  logic                              rst_n,
	input  logic [NUM_INPUTS-1:0]             line_in,
	input  logic [NUM_INPUTS-1:0]             invert_mask,
	input  logic [NUM_INPUTS-1:0]             edge_mask,
	output logic [NUM_INPUTS*(MAX_LAG+1)-1:0] pulse_hist
);

	localparam int W = MAX_LAG + 1;	// taps per line.

	logic [NUM_INPUTS-1:0] line_q;
	logic [NUM_INPUTS-1:0] samp_prev;
	logic [NUM_INPUTS-1:0] samp_now;
	logic [NUM_INPUTS-1:0] pulse_now;

	assign samp_now = line_in ^ invert_mask;
	assign samp_prev = line_q ^ invert_mask;
	// edge mode drops samples whose predecessor was already high.
	assign pulse_now = samp_now & ~(edge_mask & samp_prev);

	// bit 0 of each line slice is the current pulse, bit d is d cycles back.
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			line_q <= '0;
			pulse_hist <= '0;
		end else begin
			line_q <= line_in;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				pulse_hist[i*W +: W] <= {pulse_hist[i*W +: MAX_LAG], pulse_now[i]};
			end
		end
	end

endmodule

/* hw/corr_pkg.sv */
// Shared definitions for the coincidence correlator.
// Default top-level parameters, command opcodes, the command byte layout
// and the size helpers that every block derives its widths from.

package corr_pkg;

	// default top-level parameters.
	localparam int num_inputs_def = 4;
	localparam int lag_auto_def = 2;
	localparam int lag_cross_def = 2;
	localparam int resolution_def = 16;
	localparam int tx_gap_def = 4;

	// ****************************************
	// command opcodes
	// ****************************************
	localparam logic [3:0] op_invert = 4'd1;	// arg bit 0 sets line invert.
	localparam logic [3:0] op_edge = 4'd2;	// arg bit 0 sets rising edge mode.
	localparam logic [3:0] op_start = 4'd3;
	localparam logic [3:0] op_stop = 4'd4;

	// head byte or argument byte, same wire.
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [3:0] chan;
		} head;
		struct packed {
			logic [7:0] val;
		} data;
	} cmd_byte_u;

	localparam logic [7:0] crlf_char = 8'h0D;	// packet terminator.

	// deepest history tap needed by auto and cross lags.
	function automatic int max_lag(input int lag_auto, input int lag_cross);
		return (lag_auto > lag_cross - 1) ? lag_auto : lag_cross - 1;
	endfunction

	// pulse, auto and cross counters in one window.
	function automatic int count_total(input int n, input int lag_auto, input int lag_cross);
		return n + n * lag_auto + ((n * (n - 1)) / 2) * (2 * lag_cross - 1);
	endfunction

endpackage
